// ==== cnn_settings.svh ====
// image, feature and pooled map sizes of the pattern detector
// pixel and hit count widths and the pooling threshold
`ifndef CNN_SETTINGS_SVH
`define CNN_SETTINGS_SVH

// side of the square input image in pixels
`define CNN_IMG_DIM 8

// the cross kernel loses one pixel on every border
`define CNN_FEAT_DIM 6

// 2x2 pooling halves the feature map side
`define CNN_POOL_DIM 3

`define CNN_PIX_W 8 // only the low nibble feeds the kernel

// a pooled value counts as a hit when it is at least this large
`define CNN_THRESHOLD 20

`define CNN_COUNT_W 4 // holds up to 9 hits

`endif

// ==== cnn_pkg.sv ====
// shared types of the pattern detector
// pixels, the frame buffer, feature beats, the hit count and the walker states
`default_nettype none

package cnn_pkg;

	`include "cnn_settings.svh"

	typedef logic [`CNN_PIX_W-1:0] pixel_t;

	// pixel 0 is the top left corner, rows follow each other
	typedef pixel_t [`CNN_IMG_DIM*`CNN_IMG_DIM-1:0] frame_t;

	// 4*centre minus four neighbours of 4-bit values stays within -60..60
	typedef logic signed [7:0] feature_t;

	typedef struct packed {
		feature_t value;
		logic     last; // set on the final feature of a frame
	} feature_beat_t;

	typedef logic [`CNN_COUNT_W-1:0] hit_count_t;

	// window walker of the Laplacian stage
	typedef enum logic [1:0] {
		WALK_IDLE,  // waiting for a full frame
		WALK_RUN,   // issuing one window per cycle
		WALK_DRAIN  // frame released, pipeline emptying
	} walk_state_t;

endpackage

`default_nettype wire

// ==== frame_loader.sv ====
// frame_loader: receives pixels over a four-phase req/ack handshake
// and holds one complete frame for the convolution stage
`timescale 1ns/100ps
`default_nettype none

`include "cnn_settings.svh"

module frame_loader (
	input  logic             clk,
	input  logic             rst,
	input  logic             pix_req,
	input  cnn_pkg::pixel_t  pix_data,
	output logic             pix_ack,
	output cnn_pkg::frame_t  frame,
	output logic             frame_full,
	input  logic             frame_free
);

	localparam int NPIX  = `CNN_IMG_DIM * `CNN_IMG_DIM;
	localparam int IDX_W = $clog2(NPIX);
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(NPIX - 1);

	logic [IDX_W-1:0] pix_idx; // next pixel position, row-major
	logic             fill_done;
	logic             accept;

	// a new request is one that arrives with ack low
	// nothing is taken while the frame still belongs to the convolution
	assign accept = pix_req && !pix_ack && !frame_full && !fill_done;

	always_ff @(posedge clk) begin
		if (rst) begin
			pix_ack    <= 1'b0;
			pix_idx    <= '0;
			fill_done  <= 1'b0;
			frame_full <= 1'b0;
		end else begin
			if (accept) begin
				pix_ack <= 1'b1;
				pix_idx <= pix_idx + 1'b1; // wraps to 0 after the last pixel
			end else if (pix_ack && !pix_req) begin
				pix_ack <= 1'b0; // host released req, close the handshake
			end

			fill_done <= accept && (pix_idx == LAST_IDX);

			if (fill_done) begin
				frame_full <= 1'b1;
			end else if (frame_free) begin
				frame_full <= 1'b0;
			end
		end
	end

	// frame storage, each accepted pixel lands in its own slot
	always_ff @(posedge clk) begin
		if (accept) begin
			frame[pix_idx] <= pix_data;
		end
	end

	// back-pressure toward the host while the frame is owned downstream
	a_no_ack_when_full: assert property (
		@(posedge clk) disable iff (rst)
		frame_full && !pix_ack |=> !pix_ack
	) else $error("pix_ack raised while frame_full is high");

endmodule

`default_nettype wire

// ==== laplacian_conv.sv ====
// laplacian_conv: walks the 6x6 window positions of a held frame
// and computes 4*centre minus the cross neighbours in a two-stage pipeline
`timescale 1ns/100ps
`default_nettype none

`include "cnn_settings.svh"

module laplacian_conv (
	input  logic                   clk,
	input  logic                   rst,
	input  cnn_pkg::frame_t        frame,
	input  logic                   frame_full,
	output logic                   frame_free,
	output logic                   feat_valid,
	output cnn_pkg::feature_beat_t feat,
	input  logic                   feat_ready
);

	localparam int IMG   = `CNN_IMG_DIM;
	localparam int FEAT  = `CNN_FEAT_DIM;
	localparam int POS_W = $clog2(FEAT);
	localparam int IDX_W = $clog2(IMG * IMG);
	localparam logic [POS_W-1:0] LAST_POS = POS_W'(FEAT - 1);
	localparam logic [IDX_W-1:0] ROW_STEP = IDX_W'(IMG);

	cnn_pkg::walk_state_t state;
	logic [POS_W-1:0] row;
	logic [POS_W-1:0] col;
	logic [IDX_W-1:0] c_idx;
	logic [3:0]       nib_c;
	logic [3:0]       nib_n;
	logic [3:0]       nib_w;
	logic [3:0]       nib_e;
	logic [3:0]       nib_s;
	logic             at_end;
	logic             out_adv;
	logic             issue;
	logic             s1_valid;
	logic             s1_last;
	logic [5:0]       s1_centre; // centre nibble times four
	logic [5:0]       s1_sum;    // sum of the four cross neighbours

	// window (row, col) of the feature map is centred on image pixel (row+1, col+1)
	assign c_idx = IDX_W'((row + 1) * IMG + col + 1);
	assign nib_c = frame[c_idx][3:0];
	assign nib_n = frame[c_idx - ROW_STEP][3:0];
	assign nib_s = frame[c_idx + ROW_STEP][3:0];
	assign nib_w = frame[c_idx - 1'b1][3:0];
	assign nib_e = frame[c_idx + 1'b1][3:0];

	assign at_end  = (row == LAST_POS) && (col == LAST_POS);
	assign out_adv = !feat_valid || feat_ready; // whole pipeline moves together
	assign issue   = (state == cnn_pkg::WALK_RUN) && out_adv;

	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= cnn_pkg::WALK_IDLE;
			row        <= '0;
			col        <= '0;
			frame_free <= 1'b0;
		end else begin
			frame_free <= 1'b0;
			case (state)
				cnn_pkg::WALK_IDLE: begin
					if (frame_full)
						state <= cnn_pkg::WALK_RUN;
				end
				cnn_pkg::WALK_RUN: begin
					if (issue && at_end) begin
						state      <= cnn_pkg::WALK_DRAIN;
						frame_free <= 1'b1; // every window has read its pixels
						row        <= '0;
						col        <= '0;
					end else if (issue && col == LAST_POS) begin
						col <= '0;
						row <= row + 1'b1;
					end else if (issue) begin
						col <= col + 1'b1;
					end
				end
				cnn_pkg::WALK_DRAIN: begin
					// the old frame_full is still visible for a cycle after the pulse
					if (!frame_full && !s1_valid && !feat_valid)
						state <= cnn_pkg::WALK_IDLE;
				end
				default: state <= cnn_pkg::WALK_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			s1_valid   <= 1'b0;
			feat_valid <= 1'b0;
		end else if (out_adv) begin
			s1_valid   <= issue;
			feat_valid <= s1_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (out_adv) begin
			s1_centre  <= {nib_c, 2'b00};
			s1_sum     <= 6'(nib_n) + 6'(nib_w) + 6'(nib_e) + 6'(nib_s);
			s1_last    <= at_end;
			feat.value <= $signed({2'b00, s1_centre}) - $signed({2'b00, s1_sum});
			feat.last  <= s1_last;
		end
	end

	a_hold_on_stall: assert property (
		@(posedge clk) disable iff (rst)
		feat_valid && !feat_ready |=> feat_valid && $stable(feat)
	) else $error("feature beat changed while stalled");

endmodule

`default_nettype wire

// ==== max_pool_count.sv ====
// max_pool_count: collects the 6x6 feature map, takes the signed max
// of each 2x2 block and counts the pooled values that reach the threshold
`timescale 1ns/100ps
`default_nettype none

`include "cnn_settings.svh"

module max_pool_count (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   feat_valid,
	input  cnn_pkg::feature_beat_t feat,
	output logic                   feat_ready,
	output logic                   count_valid,
	output cnn_pkg::hit_count_t    count,
	input  logic                   count_ready
);

	localparam int FEAT   = `CNN_FEAT_DIM;
	localparam int NFEAT  = FEAT * FEAT;
	localparam int POOL   = `CNN_POOL_DIM;
	localparam int ADDR_W = $clog2(NFEAT);
	localparam int WIN_W  = $clog2(POOL);
	localparam logic [WIN_W-1:0]  LAST_WIN  = WIN_W'(POOL - 1);
	localparam logic [ADDR_W-1:0] FEAT_STEP = ADDR_W'(FEAT);
	localparam cnn_pkg::hit_count_t MAX_HITS  = cnn_pkg::hit_count_t'(POOL * POOL);
	localparam cnn_pkg::feature_t   THRESHOLD = cnn_pkg::feature_t'(`CNN_THRESHOLD);

	cnn_pkg::feature_t feat_mem [NFEAT];
	logic [ADDR_W-1:0] wr_idx;
	logic [ADDR_W-1:0] top_left;
	logic [WIN_W-1:0]  win_row;
	logic [WIN_W-1:0]  win_col;
	logic              scanning;
	logic              take;
	logic              hit;
	cnn_pkg::feature_t top_max;
	cnn_pkg::feature_t bot_max;
	cnn_pkg::feature_t win_max;

	function automatic cnn_pkg::feature_t max2(input cnn_pkg::feature_t a,
		input cnn_pkg::feature_t b);
		return (a > b) ? a : b; // signed compare, features may be negative
	endfunction

	assign feat_ready = !scanning && !count_valid;
	assign take       = feat_valid && feat_ready;

	// upper left feature of the current 2x2 block
	assign top_left = ADDR_W'(2 * win_row * FEAT + 2 * win_col);
	assign top_max  = max2(feat_mem[top_left], feat_mem[top_left + 1'b1]);
	assign bot_max  = max2(feat_mem[top_left + FEAT_STEP],
		feat_mem[top_left + FEAT_STEP + 1'b1]);
	assign win_max  = max2(top_max, bot_max);
	assign hit      = (win_max >= THRESHOLD);

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_idx      <= '0;
			scanning    <= 1'b0;
			count_valid <= 1'b0;
			win_row     <= '0;
			win_col     <= '0;
			count       <= '0;
		end else begin
			if (take) begin
				wr_idx <= feat.last ? '0 : wr_idx + 1'b1;
				if (feat.last) begin
					scanning <= 1'b1; // scan starts on the next cycle
					count    <= '0;
				end
			end

			// one pooling window per cycle, row by row
			if (scanning) begin
				count <= count + cnn_pkg::hit_count_t'(hit);
				if (win_col == LAST_WIN) begin
					win_col <= '0;
					if (win_row == LAST_WIN) begin
						win_row     <= '0;
						scanning    <= 1'b0;
						count_valid <= 1'b1;
					end else begin
						win_row <= win_row + 1'b1;
					end
				end else begin
					win_col <= win_col + 1'b1;
				end
			end

			if (count_valid && count_ready)
				count_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (take)
			feat_mem[wr_idx] <= feat.value;
	end

	a_count_range: assert property (
		@(posedge clk) disable iff (rst)
		count <= MAX_HITS
	) else $error("hit count %0d above the number of pooled values", count);

endmodule

`default_nettype wire

// ==== result_sender.sv ====
// result_sender: latches the hit count and presents it
// over a four-phase req/ack handshake
`timescale 1ns/100ps
`default_nettype none

module result_sender (
	input  logic                clk,
	input  logic                rst,
	input  logic                count_valid,
	input  cnn_pkg::hit_count_t count,
	output logic                count_ready,
	output logic                res_req,
	output cnn_pkg::hit_count_t res_count,
	input  logic                res_ack
);

	logic ack_wait; // req dropped, host ack not yet released

	// a new count is taken only once the previous handshake has fully closed
	assign count_ready = !res_req && !ack_wait;

	always_ff @(posedge clk) begin
		if (rst) begin
			res_req  <= 1'b0;
			ack_wait <= 1'b0;
		end else if (count_valid && count_ready) begin
			res_req <= 1'b1;
		end else if (res_req && res_ack) begin
			res_req  <= 1'b0;
			ack_wait <= 1'b1;
		end else if (ack_wait && !res_ack) begin
			ack_wait <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (count_valid && count_ready)
			res_count <= count;
	end

	a_count_stable: assert property (
		@(posedge clk) disable iff (rst)
		res_req |=> $stable(res_count)
	) else $error("res_count changed during the result handshake");

endmodule

`default_nettype wire

// ==== pattern_detector_top.sv ====
// pattern_detector_top: frame loader, Laplacian convolution,
// max pooling with hit count and result sender in a chain
`timescale 1ns/100ps
`default_nettype none

module pattern_detector_top (
	input  logic                clk,
	input  logic                rst,
	input  logic                pix_req,
	input  cnn_pkg::pixel_t     pix_data,
	output logic                pix_ack,
	output logic                res_req,
	output cnn_pkg::hit_count_t res_count,
	input  logic                res_ack
);

	cnn_pkg::frame_t        frame;
	logic                   frame_full;
	logic                   frame_free;
	logic                   feat_valid;
	cnn_pkg::feature_beat_t feat;
	logic                   feat_ready;
	logic                   count_valid;
	cnn_pkg::hit_count_t    count;
	logic                   count_ready;

	frame_loader u_loader (
		.clk(clk), .rst(rst),
		.pix_req(pix_req), .pix_data(pix_data), .pix_ack(pix_ack),
		.frame(frame), .frame_full(frame_full), .frame_free(frame_free)
	);

	laplacian_conv u_conv (
		.clk(clk), .rst(rst),
		.frame(frame), .frame_full(frame_full), .frame_free(frame_free),
		.feat_valid(feat_valid), .feat(feat), .feat_ready(feat_ready)
	);

	// stalls here while scanning push back into the convolution pipeline
	max_pool_count u_pool (
		.clk(clk), .rst(rst),
		.feat_valid(feat_valid), .feat(feat), .feat_ready(feat_ready),
		.count_valid(count_valid), .count(count), .count_ready(count_ready)
	);

	result_sender u_sender (
		.clk(clk), .rst(rst),
		.count_valid(count_valid), .count(count), .count_ready(count_ready),
		.res_req(res_req), .res_count(res_count), .res_ack(res_ack)
	);

endmodule

`default_nettype wire

// ==== tb_pattern_detector.sv ====
// directed testbench for the pattern detector top level
// reference model of the Laplacian, 2x2 max pooling and hit count,
// four-phase pixel and result drivers, and the test sequence
`timescale 1ns/100ps
`default_nettype none

`include "cnn_settings.svh"

module tb_pattern_detector;

	localparam int NPIX    = `CNN_IMG_DIM * `CNN_IMG_DIM;
	localparam int TIMEOUT = 2000; // cycles allowed for any single wait

	logic                clk;
	logic                rst;
	logic                pix_req;
	cnn_pkg::pixel_t     pix_data;
	logic                pix_ack;
	logic                res_req;
	cnn_pkg::hit_count_t res_count;
	logic                res_ack;

	cnn_pkg::pixel_t img [NPIX]; // frame to send next, row-major
	integer          seed;
	int              checks;
	int              errors;
	int              ack_rises = 0; // rising edges of pix_ack seen so far
	logic            ack_prev;

	pattern_detector_top DUT (
		.clk(clk), .rst(rst),
		.pix_req(pix_req), .pix_data(pix_data), .pix_ack(pix_ack),
		.res_req(res_req), .res_count(res_count), .res_ack(res_ack)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// counts acknowledges independently of the pixel driver
	always @(posedge clk) begin
		ack_prev <= pix_ack;
		if (pix_ack && !ack_prev)
			ack_rises++;
	end

	// all driving and sampling happens 2 ns after the rising edge
	task automatic step();
		@(posedge clk);
		#2;
	endtask

	task automatic abort_on_timeout(input string what);
		errors++;
		$display("timeout: %s after %0d cycles at %0t ns", what, TIMEOUT, $time);
		$display("checks: %0d, errors: %0d", checks, errors);
		$display("*** TEST FAILED ***");
		$finish;
	endtask

	task automatic check_value(input logic [31:0] got, input int exp, input string what);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	function automatic int nib(input int idx);
		return int'(img[idx][3:0]); // the kernel only sees the low nibble
	endfunction

	// 4*centre minus the cross neighbours, signed max of 2x2 blocks, threshold count
	function automatic int expected_count();
		int feat [`CNN_FEAT_DIM][`CNN_FEAT_DIM];
		int ctr;
		int best;
		int hits;
		for (int r = 0; r < `CNN_FEAT_DIM; r++) begin
			for (int c = 0; c < `CNN_FEAT_DIM; c++) begin
				ctr = (r + 1) * `CNN_IMG_DIM + c + 1;
				feat[r][c] = 4 * nib(ctr) - nib(ctr - `CNN_IMG_DIM) - nib(ctr - 1)
					- nib(ctr + 1) - nib(ctr + `CNN_IMG_DIM);
			end
		end
		hits = 0;
		for (int pr = 0; pr < `CNN_POOL_DIM; pr++) begin
			for (int pc = 0; pc < `CNN_POOL_DIM; pc++) begin
				best = feat[2*pr][2*pc];
				for (int dr = 0; dr < 2; dr++)
					for (int dc = 0; dc < 2; dc++)
						if (feat[2*pr+dr][2*pc+dc] > best)
							best = feat[2*pr+dr][2*pc+dc];
				if (best >= `CNN_THRESHOLD)
					hits++;
			end
		end
		return hits;
	endfunction

	task automatic fill_frame(input cnn_pkg::pixel_t value);
		for (int i = 0; i < NPIX; i++)
			img[i] = value;
	endtask

	task automatic fill_random();
		for (int i = 0; i < NPIX; i++)
			img[i] = cnn_pkg::pixel_t'($random(seed));
	endtask

	// first half of the pixel handshake, returns with req and ack both high
	task automatic request_pixel(input cnn_pkg::pixel_t value);
		int n;
		step();
		pix_data = value;
		pix_req  = 1'b1;
		n = 0;
		while (!pix_ack && n < TIMEOUT) begin // stalls here while the frame is held
			step();
			n++;
		end
		if (!pix_ack)
			abort_on_timeout("pix_ack did not rise");
	endtask

	// one full four-phase cycle on the pixel port
	task automatic send_pixel(input cnn_pkg::pixel_t value);
		int n;
		request_pixel(value);
		pix_req = 1'b0;
		n = 0;
		while (pix_ack && n < TIMEOUT) begin
			step();
			n++;
		end
		if (pix_ack)
			abort_on_timeout("pix_ack did not fall");
	endtask

	task automatic send_frame();
		int start;
		start = ack_rises;
		for (int i = 0; i < NPIX; i++)
			send_pixel(img[i]);
		check_value(ack_rises - start, NPIX, "acknowledged pixels");
	endtask

	task automatic wait_for_res_req();
		int n;
		n = 0;
		while (!res_req && n < TIMEOUT) begin
			step();
			n++;
		end
		if (!res_req)
			abort_on_timeout("res_req did not rise");
	endtask

	// waits for res_req, checks the count, holds ack back for hold cycles first
	task automatic get_result(input int exp, input int hold, input string what);
		int n;
		wait_for_res_req();
		check_value(res_count, exp, what);
		repeat (hold) step();
		res_ack = 1'b1;
		n = 0;
		while (res_req && n < TIMEOUT) begin
			step();
			n++;
		end
		if (res_req)
			abort_on_timeout("res_req did not fall");
		res_ack = 1'b0;
	endtask

	task automatic test_zero_frame();
		fill_frame(8'h00);
		send_frame();
		get_result(0, 0, "all-zero frame count");
	endtask

	task automatic test_single_bright();
		fill_frame(8'h00);
		img[3 * `CNN_IMG_DIM + 3] = 8'h0f; // feature 60 in the centre, -15 around it
		send_frame();
		get_result(1, 0, "single bright pixel count");
	endtask

	task automatic test_upper_nibble();
		fill_frame(8'h30);
		img[3 * `CNN_IMG_DIM + 3] = 8'hf0;
		send_frame();
		get_result(0, 0, "upper nibble frame count");
	endtask

	task automatic test_random_frames();
		int exp;
		for (int f = 0; f < 5; f++) begin
			fill_random();
			exp = expected_count();
			send_frame();
			get_result(exp, 0, "random frame count");
		end
	endtask

	task automatic test_backpressure();
		int exp1;
		int exp2;
		fill_random();
		exp1 = expected_count();
		send_frame();
		fill_random();
		exp2 = expected_count();
		fork
			send_frame();
			get_result(exp1, 50, "first count under back-pressure");
		join
		get_result(exp2, 0, "second count under back-pressure");
	endtask

	task automatic test_reset_mid_frame();
		int exp;
		fill_random();
		send_frame(); // its count stays unacknowledged
		for (int i = 0; i < 20; i++)
			send_pixel(img[i]);
		wait_for_res_req();
		request_pixel(img[20]);
		rst = 1'b1; // pixel and result handshakes are both open here
		repeat (3) step();
		rst     = 1'b0;
		pix_req = 1'b0;
		check_value(res_req, 0, "res_req after reset");
		check_value(pix_ack, 0, "pix_ack after reset");
		fill_random();
		exp = expected_count();
		send_frame();
		get_result(exp, 0, "count after mid-frame reset");
	endtask

	initial begin
		seed     = 32'h44db_616f;
		checks   = 0;
		errors   = 0;
		rst      = 1'b1;
		pix_req  = 1'b0;
		pix_data = '0;
		res_ack  = 1'b0;
		repeat (3) step();
		rst = 1'b0;
		check_value(res_req, 0, "res_req out of reset");

		test_zero_frame();
		test_single_bright();
		test_upper_nibble();
		test_random_frames();
		test_backpressure();
		test_reset_mid_frame();

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+.
cnn_pkg.sv
frame_loader.sv
laplacian_conv.sv
max_pool_count.sv
result_sender.sv
pattern_detector_top.sv
tb_pattern_detector.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the pattern detector testbench with Verilator and runs it
# the result is taken from the simulation log

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module tb_pattern_detector \
	-f src.f -o sim_tb > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "build failed"
	exit 1
fi

./obj_dir/sim_tb > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "\*\*\* TEST PASSED \*\*\*" "$SIM_LOG"; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed"
exit 1
